// ==== common/rx_pkg.sv ====
// ###############################################
// Widths, settings-bus addresses and payload types
// for the receive source stage on clk64
// Mode and rate payloads take the low data bits only
// ###############################################

package rx_pkg;

   // Sample and settings bus widths
   localparam int SAMPLE_W   = 16;
   localparam int SER_ADDR_W = 7;
   localparam int SER_DATA_W = 32;
   localparam int DECIM_W    = 8;

   // Setting register addresses
   localparam logic [SER_ADDR_W-1:0] FR_RX_MODE    = 7'd10;
   localparam logic [SER_ADDR_W-1:0] FR_DECIM_RATE = 7'd11;

   // Mode word, data bits 2..0
   typedef struct packed {
      logic enable;
      logic counter;
      logic loopback;
   } rx_mode_t;

   // Strobe period is rate + 1 clk64 cycles
   typedef logic [DECIM_W-1:0] decim_rate_t;

endpackage

// ==== common/rx_ctrl_if.sv ====
// ###############################################
// Run controls from the run FSM to timer and selector
// arm is a single-cycle pulse, run is a level
// ###############################################
`timescale 1ns/100ps

interface rx_ctrl_if
   import rx_pkg::*;
();

   logic        run;
   logic        arm;
   decim_rate_t decim_rate;
   rx_mode_t    mode;

   // FSM side drives everything
   modport fsm (
      output run,
      output arm,
      output decim_rate,
      output mode
   );

   modport user (
      input run,
      input arm,
      input decim_rate,
      input mode
   );

endinterface

// ==== rtl/setting_reg.sv ====
// ###############################################
// Settings bus register, loads one cycle after a
// strobe whose address matches ADDR
// Payload is taken from the low data bits
// ###############################################
`timescale 1ns/100ps

module setting_reg
   import rx_pkg::*;
#(
   parameter logic [SER_ADDR_W-1:0] ADDR = '0,
   parameter type payload_t = logic
)
(
   input  logic                  clk64,
   input  logic                  rx_dsp_reset,
   input  logic                  i_ser_strobe,
   input  logic [SER_ADDR_W-1:0] i_ser_addr,
   input  logic [SER_DATA_W-1:0] i_ser_data,
   output payload_t              o_value
);

   logic addr_hit;

   assign addr_hit = i_ser_strobe && (i_ser_addr == ADDR);

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         o_value <= payload_t'('0);
      end
      else if (addr_hit)
      begin
         // Keep only as many bits as the payload holds
         o_value <= payload_t'(i_ser_data[$bits(payload_t)-1:0]);
      end
   end

endmodule

// ==== rx_control/rx_run_fsm.sv ====
// ###############################################
// IDLE/ARM/RUN sequencer for the receive path
// A rate write is seen one cycle late, in step with
// the rate register output; ARM never repeats back to back
// ###############################################
`timescale 1ns/100ps

module rx_run_fsm
   import rx_pkg::*;
(
   input  logic                  clk64,
   input  logic                  rx_dsp_reset,
   input  rx_mode_t              i_mode,
   input  decim_rate_t           i_decim_rate,
   input  logic                  i_ser_strobe,
   input  logic [SER_ADDR_W-1:0] i_ser_addr,
   rx_ctrl_if.fsm                ctrl
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ARM,
      ST_RUN
   } state_t;

   state_t state;
   state_t state_nxt;
   logic   rate_wr_q;
   logic   run_q;
   logic   arm_q;

   // Next state, enable low always wins
   always_comb
   begin
      state_nxt = state;
      if (!i_mode.enable)
      begin
         state_nxt = ST_IDLE;
      end
      else
      begin
         case (state)
            ST_IDLE: state_nxt = ST_ARM;
            ST_ARM:  state_nxt = ST_RUN;
            ST_RUN:  state_nxt = rate_wr_q ? ST_ARM : ST_RUN;
            default: state_nxt = ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         state     <= ST_IDLE;
         rate_wr_q <= 1'b0;
         run_q     <= 1'b0;
         arm_q     <= 1'b0;
      end
      else
      begin
         state     <= state_nxt;
         rate_wr_q <= i_ser_strobe && (i_ser_addr == FR_DECIM_RATE);
         run_q     <= (state_nxt == ST_RUN);
         arm_q     <= (state_nxt == ST_ARM);
      end
   end

   assign ctrl.run        = run_q;
   assign ctrl.arm        = arm_q;
   // Settings pass straight through so ARM sees the new rate
   assign ctrl.decim_rate = i_decim_rate;
   assign ctrl.mode       = i_mode;

endmodule

// ==== rx_control/decim_strobe_gen.sv ====
// ###############################################
// Decimation timer, first strobe rate+1 cycles after
// ARM, then one strobe every rate+1 cycles
// Rate 0 gives a strobe on every RUN cycle
// ###############################################
`timescale 1ns/100ps

module decim_strobe_gen
   import rx_pkg::*;
(
   input  logic   clk64,
   input  logic   rx_dsp_reset,
   rx_ctrl_if.user ctrl,
   output logic   o_hb_strobe
);

   decim_rate_t cnt;

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         cnt <= '0;
      end
      else if (ctrl.arm)
      begin
         cnt <= ctrl.decim_rate;
      end
      else if (!ctrl.run)
      begin
         // Parked while stopped
         cnt <= '0;
      end
      else if (cnt == '0)
      begin
         cnt <= ctrl.decim_rate;
      end
      else
      begin
         cnt <= cnt - 1'b1;
      end
   end

   // Terminal count while running
   assign o_hb_strobe = ctrl.run && (cnt == '0);

endmodule

// ==== rx_source/rx_source_sel.sv ====
// ###############################################
// Picks ramp, loopback or baseband I/Q and registers
// it on hb_strobe; o_rx_strobe lags hb_strobe by one
// No back-pressure, every strobe must be taken
// ###############################################
`timescale 1ns/100ps

module rx_source_sel
   import rx_pkg::*;
(
   input  logic                clk64,
   input  logic                rx_dsp_reset,
   rx_ctrl_if.user             ctrl,
   input  logic                i_hb_strobe,
   input  logic [SAMPLE_W-1:0] i_bb_i,
   input  logic [SAMPLE_W-1:0] i_bb_q,
   input  logic [SAMPLE_W-1:0] i_tx_i,
   input  logic [SAMPLE_W-1:0] i_tx_q,
   input  logic                i_tx_strobe,
   output logic [SAMPLE_W-1:0] o_rx_i,
   output logic [SAMPLE_W-1:0] o_rx_q,
   output logic                o_rx_strobe
);

   logic [SAMPLE_W-1:0] ramp;
   logic [SAMPLE_W-1:0] loop_i;
   logic [SAMPLE_W-1:0] loop_q;
   logic [SAMPLE_W-1:0] sel_i;
   logic [SAMPLE_W-1:0] sel_q;

   // Debug ramp, restarts on every arm
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         ramp <= '0;
      end
      else if (ctrl.arm || !ctrl.run)
      begin
         ramp <= '0;
      end
      else if (i_hb_strobe)
      begin
         ramp <= ramp + SAMPLE_W'(2);
      end
   end

   // Transmit loopback capture
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         loop_i <= '0;
         loop_q <= '0;
      end
      else if (i_tx_strobe)
      begin
         loop_i <= i_tx_i;
         loop_q <= i_tx_q;
      end
   end

   // Counter over loopback over baseband
   always_comb
   begin
      if (ctrl.mode.counter)
      begin
         sel_i = ramp;
         sel_q = ramp + SAMPLE_W'(1);
      end
      else if (ctrl.mode.loopback)
      begin
         sel_i = loop_i;
         sel_q = loop_q;
      end
      else
      begin
         sel_i = i_bb_i;
         sel_q = i_bb_q;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         o_rx_strobe <= 1'b0;
      end
      else
      begin
         o_rx_strobe <= i_hb_strobe;
      end
   end

   // Sample payload, held between strobes
   always_ff @(posedge clk64)
   begin
      if (i_hb_strobe)
      begin
         o_rx_i <= sel_i;
         o_rx_q <= sel_q;
      end
   end

endmodule

// ==== rtl/rx_front_top.sv ====
// ###############################################
// Receive sample source stage on clk64
// Mode write to first o_rx_strobe is rate+4 cycles
// Settings bus and sample bus are plain ports
// ###############################################
`timescale 1ns/100ps

module rx_front_top
   import rx_pkg::*;
(
   input  logic                  clk64,
   input  logic                  rx_dsp_reset,
   input  logic                  i_ser_strobe,
   input  logic [SER_ADDR_W-1:0] i_ser_addr,
   input  logic [SER_DATA_W-1:0] i_ser_data,
   input  logic [SAMPLE_W-1:0]   i_bb_i,
   input  logic [SAMPLE_W-1:0]   i_bb_q,
   input  logic [SAMPLE_W-1:0]   i_tx_i,
   input  logic [SAMPLE_W-1:0]   i_tx_q,
   input  logic                  i_tx_strobe,
   output logic [SAMPLE_W-1:0]   o_rx_i,
   output logic [SAMPLE_W-1:0]   o_rx_q,
   output logic                  o_rx_strobe
);

   rx_mode_t    mode;
   decim_rate_t decim_rate;
   logic        hb_strobe;

   rx_ctrl_if ctrl_if ();

   setting_reg #(.ADDR(FR_RX_MODE), .payload_t(rx_mode_t)) u_sr_mode (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_ser_strobe (i_ser_strobe),
      .i_ser_addr   (i_ser_addr),
      .i_ser_data   (i_ser_data),
      .o_value      (mode)
   );

   setting_reg #(.ADDR(FR_DECIM_RATE), .payload_t(decim_rate_t)) u_sr_rate (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_ser_strobe (i_ser_strobe),
      .i_ser_addr   (i_ser_addr),
      .i_ser_data   (i_ser_data),
      .o_value      (decim_rate)
   );

   rx_run_fsm u_run_fsm (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_mode       (mode),
      .i_decim_rate (decim_rate),
      .i_ser_strobe (i_ser_strobe),
      .i_ser_addr   (i_ser_addr),
      .ctrl         (ctrl_if.fsm)
   );

   decim_strobe_gen u_strobe_gen (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .ctrl         (ctrl_if.user),
      .o_hb_strobe  (hb_strobe)
   );

   rx_source_sel u_source_sel (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .ctrl         (ctrl_if.user),
      .i_hb_strobe  (hb_strobe),
      .i_bb_i       (i_bb_i),
      .i_bb_q       (i_bb_q),
      .i_tx_i       (i_tx_i),
      .i_tx_q       (i_tx_q),
      .i_tx_strobe  (i_tx_strobe),
      .o_rx_i       (o_rx_i),
      .o_rx_q       (o_rx_q),
      .o_rx_strobe  (o_rx_strobe)
   );

endmodule

// ==== dv/rx_front_chk.sv ====
// ##################################################
// Bound checks on rx_front_top strobes and arm pulses
// fail_count holds the number of failed assertions
// ##################################################
`timescale 1ns/100ps

module rx_front_chk
   import rx_pkg::*;
(
   input logic        clk64,
   input logic        rx_dsp_reset,
   input logic        i_run,
   input logic        i_arm,
   input decim_rate_t i_decim_rate,
   input logic        i_hb_strobe,
   input logic        i_rx_strobe
);

   int fail_count = 0;

   // o_rx_strobe lags hb_strobe, so run is taken one cycle back
   a_strobe_needs_run: assert property (
      @(posedge clk64) disable iff (rx_dsp_reset)
      i_rx_strobe |-> $past(i_run)
   )
   else
   begin
      fail_count++;
      $error("o_rx_strobe seen although the receive path was not running");
   end

   a_hb_single: assert property (
      @(posedge clk64) disable iff (rx_dsp_reset)
      (i_hb_strobe && i_decim_rate != '0) |=> !i_hb_strobe
   )
   else
   begin
      fail_count++;
      $error("hb_strobe high in two cycles in a row with a nonzero rate");
   end

   a_arm_pulse: assert property (
      @(posedge clk64) disable iff (rx_dsp_reset)
      i_arm |=> !i_arm
   )
   else
   begin
      fail_count++;
      $error("arm held high for more than one cycle");
   end

endmodule

// ==== dv/tb_rx_front.sv ====
// ##################################################
// Table-driven testbench for rx_front_top on clk64
// Rows with a mid-run rate rewrite need a rate of 2 or more
// Outputs are sampled and inputs driven on the falling edge
// ##################################################
`timescale 1ns/100ps

module tb_rx_front
   import rx_pkg::*;
();

   localparam int CLK_PERIOD   = 40;
   localparam int NUM_ROWS     = 8;
   localparam int QUIET_CYCLES = 14;
   // Setup, restart and disable cycles of one row
   localparam int ROW_OVERHEAD = 40;

   typedef struct packed {
      decim_rate_t rate;
      logic [2:0]  mode;
      logic [7:0]  n_strobes;
      logic        stray;
      logic        rewrite;
   } row_t;

   // Mode bits are enable, counter, loopback
   string row_name [NUM_ROWS] = '{"spacing_r0", "spacing_r3", "spacing_r9", "ramp_restart",
                                  "loopback", "ramp_over_loop", "stray_write", "stray_ramp"};
   row_t  rows [NUM_ROWS] = '{
      '{8'd0, 3'b100, 8'd8, 1'b0, 1'b0},
      '{8'd3, 3'b110, 8'd6, 1'b0, 1'b0},
      '{8'd9, 3'b100, 8'd4, 1'b0, 1'b0},
      '{8'd3, 3'b110, 8'd8, 1'b0, 1'b1},
      '{8'd2, 3'b101, 8'd8, 1'b0, 1'b0},
      '{8'd2, 3'b111, 8'd6, 1'b0, 1'b0},
      '{8'd4, 3'b100, 8'd6, 1'b1, 1'b0},
      '{8'd1, 3'b110, 8'd6, 1'b1, 1'b0}
   };

   logic                  clk64;
   logic                  rx_dsp_reset;
   logic                  i_ser_strobe;
   logic [SER_ADDR_W-1:0] i_ser_addr;
   logic [SER_DATA_W-1:0] i_ser_data;
   logic [SAMPLE_W-1:0]   i_bb_i;
   logic [SAMPLE_W-1:0]   i_bb_q;
   logic [SAMPLE_W-1:0]   i_tx_i;
   logic [SAMPLE_W-1:0]   i_tx_q;
   logic                  i_tx_strobe;
   logic [SAMPLE_W-1:0]   o_rx_i;
   logic [SAMPLE_W-1:0]   o_rx_q;
   logic                  o_rx_strobe;

   // Reference model state
   int                    cyc = 0;
   int                    checks = 0;
   int                    errors = 0;
   bit                    running = 1'b0;
   bit                    seen = 1'b0;
   int                    next_due = 0;
   int                    stop_at = 0;
   int                    ramp_k = 0;
   int                    n_seen = 0;
   int                    cur_rate = 0;
   logic [2:0]            cur_mode = 3'b000;
   string                 test_name = "reset";
   logic [SAMPLE_W-1:0]   loop_i_m = '0;
   logic [SAMPLE_W-1:0]   loop_q_m = '0;

   initial clk64 = 1'b0;
   always #(CLK_PERIOD / 2) clk64 = ~clk64;

   rx_front_top u_dut (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_ser_strobe (i_ser_strobe),
      .i_ser_addr   (i_ser_addr),
      .i_ser_data   (i_ser_data),
      .i_bb_i       (i_bb_i),
      .i_bb_q       (i_bb_q),
      .i_tx_i       (i_tx_i),
      .i_tx_q       (i_tx_q),
      .i_tx_strobe  (i_tx_strobe),
      .o_rx_i       (o_rx_i),
      .o_rx_q       (o_rx_q),
      .o_rx_strobe  (o_rx_strobe)
   );

   bind rx_front_top rx_front_chk u_chk (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_run        (ctrl_if.run),
      .i_arm        (ctrl_if.arm),
      .i_decim_rate (decim_rate),
      .i_hb_strobe  (hb_strobe),
      .i_rx_strobe  (o_rx_strobe)
   );

   task automatic check_value(input string name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
      checks++;
      if (act_val !== exp_val)
      begin
         errors++;
         $display("Mismatch %s: expected 0x%0h, actual 0x%0h at %0t",
                  name, exp_val, act_val, $time);
      end
   endtask

   // Settings bus word plus fresh random baseband and transmit samples
   task automatic drive_inputs(input logic stb, input logic [SER_ADDR_W-1:0] addr,
                               input logic [SER_DATA_W-1:0] data);
      i_ser_strobe = stb;
      i_ser_addr   = addr;
      i_ser_data   = data;
      i_bb_i       = SAMPLE_W'($urandom);
      i_bb_q       = SAMPLE_W'($urandom);
      i_tx_i       = SAMPLE_W'($urandom);
      i_tx_q       = SAMPLE_W'($urandom);
      i_tx_strobe  = ($urandom % 4) == 0;
   endtask

   // One cycle: compare outputs with the model, then follow the loopback capture
   task automatic step_cycle();
      logic        exp_stb;
      logic [31:0] exp_i;
      logic [31:0] exp_q;
      @(negedge clk64);
      cyc++;
      if (running && cyc >= stop_at)
      begin
         running = 1'b0;
      end
      exp_stb = running && (cyc == next_due);
      check_value({test_name, " strobe"}, 32'(exp_stb), 32'(o_rx_strobe));
      seen = exp_stb;
      if (exp_stb)
      begin
         if (cur_mode[1])
         begin
            exp_i = 32'(2 * ramp_k);
            exp_q = 32'(2 * ramp_k + 1);
         end
         else if (cur_mode[0])
         begin
            exp_i = 32'(loop_i_m);
            exp_q = 32'(loop_q_m);
         end
         else
         begin
            // Pair driven last cycle, still on the inputs
            exp_i = 32'(i_bb_i);
            exp_q = 32'(i_bb_q);
         end
         if (o_rx_strobe)
         begin
            check_value({test_name, " i"}, exp_i, 32'(o_rx_i));
            check_value({test_name, " q"}, exp_q, 32'(o_rx_q));
         end
         ramp_k++;
         n_seen++;
         next_due = cyc + cur_rate + 1;
      end
      // Captured at the rising edge just passed
      if (i_tx_strobe)
      begin
         loop_i_m = i_tx_i;
         loop_q_m = i_tx_q;
      end
   endtask

   initial
   begin
      void'($urandom(32'h4f148d1f));
      rx_dsp_reset = 1'b1;
      drive_inputs(1'b0, '0, '0);
      repeat (2) @(negedge clk64);
      rx_dsp_reset = 1'b0;
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         test_name = row_name[r];
         cur_rate  = int'(rows[r].rate);
         step_cycle();
         drive_inputs(1'b1, FR_DECIM_RATE, SER_DATA_W'(rows[r].rate));
         step_cycle();
         drive_inputs(1'b1, FR_RX_MODE, SER_DATA_W'(rows[r].mode));
         cur_mode = rows[r].mode;
         running  = 1'b1;
         next_due = cyc + cur_rate + 4;
         stop_at  = 32'h7fff_ffff;
         ramp_k   = 0;
         n_seen   = 0;
         while (n_seen < int'(rows[r].n_strobes))
         begin
            step_cycle();
            if (seen && rows[r].stray && n_seen == 1)
            begin
               drive_inputs(1'b1, SER_ADDR_W'(12 + ($urandom % 100)), $urandom);
            end
            else if (seen && rows[r].rewrite && n_seen == int'(rows[r].n_strobes) / 2)
            begin
               // Same rate again, path re-arms and the ramp restarts
               drive_inputs(1'b1, FR_DECIM_RATE, SER_DATA_W'(rows[r].rate));
               next_due = cyc + cur_rate + 4;
               ramp_k   = 0;
            end
            else
            begin
               drive_inputs(1'b0, '0, '0);
            end
         end
         // Clear enable only; strobes already in flight still arrive
         step_cycle();
         drive_inputs(1'b1, FR_RX_MODE, SER_DATA_W'(rows[r].mode & 3'b011));
         stop_at = cyc + 3;
         repeat (QUIET_CYCLES)
         begin
            step_cycle();
            drive_inputs(1'b0, '0, '0);
         end
      end
      $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
               checks, errors, u_dut.u_chk.fail_count);
      if (errors == 0 && u_dut.u_chk.fail_count == 0)
      begin
         $display("TEST OK");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Watchdog sized from the table
   initial
   begin
      int limit;
      limit = 100;
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         limit += int'(rows[r].n_strobes) * (int'(rows[r].rate) + 1) + ROW_OVERHEAD;
      end
      #(limit * CLK_PERIOD);
      $display("Run timed out after %0d clk64 cycles without finishing", limit);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== verilog.f ====
common/rx_pkg.sv
common/rx_ctrl_if.sv
rtl/setting_reg.sv
rx_control/rx_run_fsm.sv
rx_control/decim_strobe_gen.sv
rx_source/rx_source_sel.sv
rtl/rx_front_top.sv
dv/rx_front_chk.sv
dv/tb_rx_front.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build tb_rx_front with Verilator, run it, and decide pass or fail from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f \
   --top-module tb_rx_front -o tb_rx_front \
   && ./obj_dir/tb_rx_front | tee sim.log \
   || echo "Build or simulation stopped with an error"

grep -qs "^TEST OK$" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
